// File: list.f
src/uart_rx_pkg.sv
src/rx_input_filter.sv
src/uart_rx_controller.sv
src/uart_rx_datapath.sv
src/uart_rx_channel.sv
src/rx_output_arbiter.sv
src/uart_rx_hub.sv
tb/uart_rx_hub_tb.sv

// File: tb/uart_rx_hub_tb.sv
module uart_rx_hub_tb;

    localparam int NUM_CHANNELS = 4;
    localparam int CLKS_PER_BIT = 16;
    localparam int FRAME_CYCLES = 10 * CLKS_PER_BIT;
    // About forty frames with their handshakes and idle gaps, doubled.
    localparam int MAX_CYCLES   = 2 * 40 * (FRAME_CYCLES + 90);

    logic                    clk;
    logic                    reset_b;
    logic [NUM_CHANNELS-1:0] rx_line;
    logic                    out_ack;
    logic                    out_req;
    logic [7:0]              out_data;
    logic [1:0]              out_channel;
    logic                    out_frame_err;
    logic                    out_overrun;

    // Received words are kept as {channel, frame_err, overrun, data}.
    logic [11:0] out_word;
    logic [11:0] words [$];
    logic        ack_enable;
    int          errors;
    int          tests_passed;
    int          tests_failed;
    int          rr_ptr;
    int          seed;
    int          cycles;

    assign out_word = {out_channel, out_frame_err, out_overrun, out_data};

    uart_rx_hub #(
        .NUM_CHANNELS (NUM_CHANNELS),
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) i_uart_rx_hub (
        .clk           (clk),
        .reset_b       (reset_b),
        .rx_line       (rx_line),
        .out_ack       (out_ack),
        .out_req       (out_req),
        .out_data      (out_data),
        .out_channel   (out_channel),
        .out_frame_err (out_frame_err),
        .out_overrun   (out_overrun)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic report_fault(input string msg);
        $display("ERROR: %s", msg);
        errors++;
    endtask

    // Drives start, data LSB first, then the stop bit, and leaves the line at
    // the stop level. Called on a rising edge and returns on one.
    task automatic send_frame(input int ch, input logic [7:0] data, input logic stop);
        logic [9:0] bits;
        bits = {stop, data, 1'b0};
        for (int i = 0; i < 10; i++) begin
            rx_line[ch] <= bits[i];
            repeat (CLKS_PER_BIT) @(posedge clk);
        end
    endtask

    task automatic expect_word(input string name, input int ch, input logic [7:0] data,
                               input logic fe, input logic ov);
        logic [11:0] exp_w;
        logic [11:0] act_w;
        exp_w = {ch[1:0], fe, ov, data};
        while (words.size() == 0) begin
            @(posedge clk);
        end
        act_w = words.pop_front();
        assert (act_w == exp_w) else begin
            $display("MISMATCH %s: expected ch%0d %02h fe%b ov%b, actual ch%0d %02h fe%b ov%b",
                     name, exp_w[11:10], exp_w[7:0], exp_w[9], exp_w[8],
                     act_w[11:10], act_w[7:0], act_w[9], act_w[8]);
            errors++;
        end
        rr_ptr = (ch + 1) % NUM_CHANNELS;
    endtask

    task automatic expect_quiet(input string name, input int wait_cycles);
        repeat (wait_cycles) @(posedge clk);
        assert (words.size() == 0) else begin
            $display("MISMATCH %s: expected 0 extra words, actual %0d", name, words.size());
            errors++;
        end
    endtask

    task automatic close_test(input string name, input int first_err);
        repeat (20) @(posedge clk);
        if (errors == first_err) begin
            tests_passed++;
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: %0d errors", name, errors - first_err);
        end
    endtask

    task automatic single_byte();
        int first_err;
        first_err = errors;
        send_frame(0, 8'hA5, 1'b1);
        expect_word("single_byte", 0, 8'hA5, 1'b0, 1'b0);
        close_test("single_byte", first_err);
    endtask

    task automatic all_channels();
        logic [7:0] sent [4];
        int         first_err;
        int         ch;
        first_err = errors;
        sent = '{8'hC3, 8'h96, 8'h0F, 8'hF0};
        fork
            send_frame(0, sent[0], 1'b1);
            send_frame(1, sent[1], 1'b1);
            send_frame(2, sent[2], 1'b1);
            send_frame(3, sent[3], 1'b1);
        join
        // All four become valid together, so the grant order follows the pointer.
        for (int k = 0; k < NUM_CHANNELS; k++) begin
            ch = rr_ptr;
            expect_word("all_channels", ch, sent[ch], 1'b0, 1'b0);
        end
        expect_quiet("all_channels", 2 * CLKS_PER_BIT);
        close_test("all_channels", first_err);
    endtask

    task automatic framing_error();
        int first_err;
        first_err = errors;
        send_frame(2, 8'h3C, 1'b0);
        repeat (40) @(posedge clk);
        rx_line[2] <= 1'b1;
        repeat (20) @(posedge clk);
        send_frame(2, 8'h81, 1'b1);
        expect_word("framing_error", 2, 8'h3C, 1'b1, 1'b0);
        expect_word("framing_error", 2, 8'h81, 1'b0, 1'b0);
        close_test("framing_error", first_err);
    endtask

    task automatic false_start();
        int first_err;
        first_err = errors;
        rx_line[1] <= 1'b0;
        @(posedge clk);
        rx_line[1] <= 1'b1;
        repeat (40) @(posedge clk);
        rx_line[1] <= 1'b0;
        repeat (5) @(posedge clk);
        rx_line[1] <= 1'b1;
        // A wrongly accepted start would only deliver a word a whole frame later.
        expect_quiet("false_start", 2 * FRAME_CYCLES);
        send_frame(1, 8'h5A, 1'b1);
        expect_word("false_start", 1, 8'h5A, 1'b0, 1'b0);
        close_test("false_start", first_err);
    endtask

    task automatic overrun_backpressure();
        int first_err;
        first_err = errors;
        ack_enable <= 1'b0;
        send_frame(3, 8'h11, 1'b1);
        send_frame(3, 8'h22, 1'b1);
        send_frame(3, 8'h33, 1'b1);
        repeat (10) @(posedge clk);
        assert (out_req && out_data == 8'h11) else begin
            $display("MISMATCH %s: expected req 1 data 11, actual req %b data %02h",
                     "overrun_backpressure", out_req, out_data);
            errors++;
        end
        ack_enable <= 1'b1;
        expect_word("overrun_backpressure", 3, 8'h11, 1'b0, 1'b0);
        expect_word("overrun_backpressure", 3, 8'h22, 1'b0, 1'b1);
        expect_quiet("overrun_backpressure", 2 * CLKS_PER_BIT);
        close_test("overrun_backpressure", first_err);
    endtask

    task automatic random_traffic();
        logic [31:0] rnd;
        int          first_err;
        int          ch;
        first_err = errors;
        for (int n = 0; n < 16; n++) begin
            rnd = $random(seed);
            ch  = rnd[1:0];
            send_frame(ch, rnd[11:4], 1'b1);
            expect_word("random_traffic", ch, rnd[11:4], 1'b0, 1'b0);
        end
        expect_quiet("random_traffic", 2 * CLKS_PER_BIT);
        close_test("random_traffic", first_err);
    endtask

    // Sink side of the output handshake. The ack delay cycles through 0 to 3.
    initial begin : sink
        int ack_delay;
        ack_delay = 0;
        forever begin
            @(posedge clk);
            if (out_req && !out_ack && ack_enable) begin
                words.push_back(out_word);
                repeat (ack_delay) @(posedge clk);
                out_ack <= 1'b1;
                do begin
                    @(posedge clk);
                end while (out_req);
                out_ack   <= 1'b0;
                ack_delay = (ack_delay + 1) % 4;
            end
        end
    end

    initial begin : protocol_monitor
        logic        prev_req;
        logic        prev_ack;
        logic [11:0] prev_word;
        prev_req  = 1'b0;
        prev_ack  = 1'b0;
        prev_word = '0;
        forever begin
            @(posedge clk);
            if (reset_b) begin
                assert (!(out_req && !prev_req && out_ack))
                    else report_fault("out_req rose while out_ack was high");
                assert (!(out_req && prev_req && out_word != prev_word))
                    else report_fault("output word changed while out_req was high");
                assert (!(prev_req && !out_req && !prev_ack))
                    else report_fault("out_req dropped before out_ack was raised");
            end
            prev_req  = out_req;
            prev_ack  = out_ack;
            prev_word = out_word;
        end
    end

    initial begin : watchdog
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        reset_b      = 1'b0;
        rx_line      = '1;
        out_ack      = 1'b0;
        ack_enable   = 1'b1;
        errors       = 0;
        tests_passed = 0;
        tests_failed = 0;
        rr_ptr       = 0;
        seed         = 58;
        repeat (4) @(posedge clk);
        reset_b <= 1'b1;
        repeat (4) @(posedge clk);

        single_byte();
        all_channels();
        framing_error();
        false_start();
        overrun_backpressure();
        random_traffic();

        $display("Tests passed: %0d, failed: %0d, failed checks: %0d",
                 tests_passed, tests_failed, errors);
        if (tests_failed == 0 && errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: src/uart_rx_hub.sv
module uart_rx_hub #(
    parameter int NUM_CHANNELS = 4,
    parameter int CLKS_PER_BIT = 55
) (
    input  logic                                clk,
    input  logic                                reset_b,
    input  logic [NUM_CHANNELS-1:0]             rx_line,
    input  logic                                out_ack,
    output logic                                out_req,
    output logic [uart_rx_pkg::DATA_BITS-1:0]   out_data,
    output logic [$clog2(NUM_CHANNELS)-1:0]     out_channel,
    output logic                                out_frame_err,
    output logic                                out_overrun
);

    logic [NUM_CHANNELS-1:0]                             clean_line;
    logic [NUM_CHANNELS-1:0]                             byte_valid;
    logic [NUM_CHANNELS-1:0][uart_rx_pkg::DATA_BITS-1:0] byte_data;
    logic [NUM_CHANNELS-1:0]                             frame_err;
    logic [NUM_CHANNELS-1:0]                             overrun;
    logic [NUM_CHANNELS-1:0]                             take;

    rx_input_filter #(
        .NUM_CHANNELS (NUM_CHANNELS)
    ) i_rx_input_filter (
        .clk        (clk),
        .reset_b    (reset_b),
        .rx_line    (rx_line),
        .clean_line (clean_line)
    );

    for (genvar i = 0; i < NUM_CHANNELS; i++) begin : g_channel
        uart_rx_channel #(
            .CLKS_PER_BIT (CLKS_PER_BIT)
        ) i_uart_rx_channel (
            .clk        (clk),
            .reset_b    (reset_b),
            .line       (clean_line[i]),
            .take       (take[i]),
            .byte_valid (byte_valid[i]),
            .byte_data  (byte_data[i]),
            .frame_err  (frame_err[i]),
            .overrun    (overrun[i])
        );
    end

    rx_output_arbiter #(
        .NUM_CHANNELS (NUM_CHANNELS)
    ) i_rx_output_arbiter (
        .clk           (clk),
        .reset_b       (reset_b),
        .byte_valid    (byte_valid),
        .byte_data     (byte_data),
        .frame_err     (frame_err),
        .overrun       (overrun),
        .take          (take),
        .out_ack       (out_ack),
        .out_req       (out_req),
        .out_data      (out_data),
        .out_channel   (out_channel),
        .out_frame_err (out_frame_err),
        .out_overrun   (out_overrun)
    );

endmodule

// File: src/rx_output_arbiter.sv
module rx_output_arbiter #(
    parameter int NUM_CHANNELS = 4
) (
    input  logic                                                clk,
    input  logic                                                reset_b,
    input  logic [NUM_CHANNELS-1:0]                             byte_valid,
    input  logic [NUM_CHANNELS-1:0][uart_rx_pkg::DATA_BITS-1:0] byte_data,
    input  logic [NUM_CHANNELS-1:0]                             frame_err,
    input  logic [NUM_CHANNELS-1:0]                             overrun,
    output logic [NUM_CHANNELS-1:0]                             take,
    input  logic                                                out_ack,
    output logic                                                out_req,
    output logic [uart_rx_pkg::DATA_BITS-1:0]                   out_data,
    output logic [$clog2(NUM_CHANNELS)-1:0]                     out_channel,
    output logic                                                out_frame_err,
    output logic                                                out_overrun
);

    localparam int CH_W = $clog2(NUM_CHANNELS);

    localparam logic [1:0] IDLE         = 2'b00;
    localparam logic [1:0] REQ          = 2'b01;
    localparam logic [1:0] WAIT_ACK_LOW = 2'b10;

    logic [1:0]      state;
    logic [CH_W-1:0] ptr;
    logic            grant_found;
    logic [CH_W-1:0] grant_idx;
    logic            grant;

    // Scan from the pointer upward and wrap, so the first valid channel
    // found is the next one in round-robin order.
    always_comb begin
        int cand;
        grant_found = 1'b0;
        grant_idx   = '0;
        for (int k = 0; k < NUM_CHANNELS; k++) begin
            cand = int'(ptr) + k;
            if (cand >= NUM_CHANNELS) begin
                cand = cand - NUM_CHANNELS;
            end
            if (!grant_found && byte_valid[cand]) begin
                grant_found = 1'b1;
                grant_idx   = CH_W'(cand);
            end
        end
    end

    // A new word is only taken once the sink has released out_ack.
    assign grant = (state == IDLE) && !out_ack && grant_found;

    always_comb begin
        take = '0;
        if (grant) begin
            take[grant_idx] = 1'b1;
        end
    end

    assign out_req = (state == REQ);

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            state <= IDLE;
            ptr   <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (grant) begin
                        state <= REQ;
                        if (grant_idx == CH_W'(NUM_CHANNELS - 1)) begin
                            ptr <= '0;
                        end else begin
                            ptr <= grant_idx + 1'b1;
                        end
                    end
                end
                REQ: begin
                    if (out_ack) begin
                        state <= WAIT_ACK_LOW;
                    end
                end
                WAIT_ACK_LOW: begin
                    if (!out_ack) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // The output word only changes on a grant, so it holds for the whole exchange.
    always_ff @(posedge clk) begin
        if (grant) begin
            out_data      <= byte_data[grant_idx];
            out_channel   <= grant_idx;
            out_frame_err <= frame_err[grant_idx];
            out_overrun   <= overrun[grant_idx];
        end
    end

endmodule

// File: src/uart_rx_channel.sv
module uart_rx_channel #(
    parameter int CLKS_PER_BIT = 55
) (
    input  logic                                clk,
    input  logic                                reset_b,
    input  logic                                line,
    input  logic                                take,
    output logic                                byte_valid,
    output logic [uart_rx_pkg::DATA_BITS-1:0]   byte_data,
    output logic                                frame_err,
    output logic                                overrun
);

    uart_rx_pkg::ctr_sel_t                 baud_sel;
    uart_rx_pkg::ctr_sel_t                 bit_sel;
    uart_rx_pkg::shift_sel_t               shift_sel;
    logic                                  half_reached;
    logic                                  baud_reached;
    logic                                  bits_done;
    logic                                  frame_done;
    logic                                  stop_ok;
    logic [uart_rx_pkg::DATA_BITS-1:0]     shift_data;
    logic                                  load;

    uart_rx_controller #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) i_uart_rx_controller (
        .clk          (clk),
        .reset_b      (reset_b),
        .line         (line),
        .half_reached (half_reached),
        .baud_reached (baud_reached),
        .bits_done    (bits_done),
        .baud_sel     (baud_sel),
        .bit_sel      (bit_sel),
        .shift_sel    (shift_sel),
        .frame_done   (frame_done),
        .stop_ok      (stop_ok)
    );

    uart_rx_datapath #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) i_uart_rx_datapath (
        .clk          (clk),
        .reset_b      (reset_b),
        .line         (line),
        .baud_sel     (baud_sel),
        .bit_sel      (bit_sel),
        .shift_sel    (shift_sel),
        .half_reached (half_reached),
        .baud_reached (baud_reached),
        .bits_done    (bits_done),
        .shift_data   (shift_data)
    );

    // A finished frame is stored if the register is empty or is being
    // drained on this same edge.
    assign load = frame_done && (!byte_valid || take);

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            byte_valid <= 1'b0;
            frame_err  <= 1'b0;
            overrun    <= 1'b0;
        end else if (load) begin
            byte_valid <= 1'b1;
            frame_err  <= !stop_ok;
            overrun    <= 1'b0;
        end else if (frame_done) begin
            // The new byte is lost and the held word records it.
            overrun <= 1'b1;
        end else if (take) begin
            byte_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            byte_data <= shift_data;
        end
    end

endmodule

// File: src/uart_rx_datapath.sv
module uart_rx_datapath #(
    parameter int CLKS_PER_BIT = 55
) (
    input  logic                                clk,
    input  logic                                reset_b,
    input  logic                                line,
    input  uart_rx_pkg::ctr_sel_t               baud_sel,
    input  uart_rx_pkg::ctr_sel_t               bit_sel,
    input  uart_rx_pkg::shift_sel_t             shift_sel,
    output logic                                half_reached,
    output logic                                baud_reached,
    output logic                                bits_done,
    output logic [uart_rx_pkg::DATA_BITS-1:0]   shift_data
);

    localparam int BAUD_W    = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
    localparam int BIT_W     = $clog2(uart_rx_pkg::DATA_BITS);
    localparam int HALF_LAST = CLKS_PER_BIT / 2 - 1;

    logic [BAUD_W-1:0] baud_cnt;
    logic [BIT_W-1:0]  bit_cnt;

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            baud_cnt <= '0;
        end else begin
            case (baud_sel)
                uart_rx_pkg::CTR_ZERO: baud_cnt <= '0;
                uart_rx_pkg::CTR_INC:  baud_cnt <= baud_cnt + 1'b1;
                default:               baud_cnt <= baud_cnt;
            endcase
        end
    end

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            bit_cnt <= '0;
        end else begin
            case (bit_sel)
                uart_rx_pkg::CTR_ZERO: bit_cnt <= '0;
                uart_rx_pkg::CTR_INC:  bit_cnt <= bit_cnt + 1'b1;
                default:               bit_cnt <= bit_cnt;
            endcase
        end
    end

    assign half_reached = (HALF_LAST >= 0) && (baud_cnt == BAUD_W'(HALF_LAST));
    assign baud_reached = baud_cnt == BAUD_W'(CLKS_PER_BIT - 1);

    // True while the sample being taken is the last data bit of the frame.
    assign bits_done = bit_cnt == BIT_W'(uart_rx_pkg::DATA_BITS - 1);

    // Bits arrive LSB first, so shifting right from the top leaves the byte
    // aligned after the last data bit.
    always_ff @(posedge clk) begin
        if (shift_sel == uart_rx_pkg::SHIFT_IN) begin
            shift_data <= {line, shift_data[uart_rx_pkg::DATA_BITS-1:1]};
        end
    end

endmodule

// File: src/uart_rx_controller.sv
module uart_rx_controller #(
    parameter int CLKS_PER_BIT = 55
) (
    input  logic                    clk,
    input  logic                    reset_b,
    input  logic                    line,
    input  logic                    half_reached,
    input  logic                    baud_reached,
    input  logic                    bits_done,
    output uart_rx_pkg::ctr_sel_t   baud_sel,
    output uart_rx_pkg::ctr_sel_t   bit_sel,
    output uart_rx_pkg::shift_sel_t shift_sel,
    output logic                    frame_done,
    output logic                    stop_ok
);

    localparam logic [1:0] IDLE        = 2'b00;
    localparam logic [1:0] START_CHECK = 2'b01;
    localparam logic [1:0] DATA        = 2'b10;
    localparam logic [1:0] STOP        = 2'b11;

    // A bit shorter than two clocks has no middle to wait for, so the start
    // bit is confirmed on the first counted cycle.
    localparam bit NO_HALF = CLKS_PER_BIT < 2;

    logic [1:0] state;
    logic [1:0] next_state;
    logic       wait_high;
    logic       start_sample;

    assign start_sample = half_reached || NO_HALF;

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    // Set after a low stop bit. The line has to come back high before the
    // controller looks for another start.
    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            wait_high <= 1'b0;
        end else if (frame_done && !line) begin
            wait_high <= 1'b1;
        end else if (line) begin
            wait_high <= 1'b0;
        end
    end

    always_comb begin
        baud_sel   = uart_rx_pkg::CTR_ZERO;
        bit_sel    = uart_rx_pkg::CTR_ZERO;
        shift_sel  = uart_rx_pkg::SHIFT_HOLD;
        frame_done = 1'b0;
        stop_ok    = 1'b1;
        next_state = state;

        case (state)
            IDLE: begin
                if (!line) begin
                    next_state = START_CHECK;
                end
            end

            START_CHECK: begin
                if (start_sample) begin
                    // A high line at mid start bit was only noise.
                    if (line) begin
                        next_state = IDLE;
                    end else begin
                        next_state = DATA;
                    end
                end else begin
                    baud_sel = uart_rx_pkg::CTR_INC;
                end
            end

            DATA: begin
                if (baud_reached) begin
                    bit_sel   = uart_rx_pkg::CTR_INC;
                    shift_sel = uart_rx_pkg::SHIFT_IN;
                    if (bits_done) begin
                        next_state = STOP;
                    end
                end else begin
                    baud_sel = uart_rx_pkg::CTR_INC;
                    bit_sel  = uart_rx_pkg::CTR_HOLD;
                end
            end

            STOP: begin
                if (wait_high) begin
                    if (line) begin
                        next_state = IDLE;
                    end
                end else if (baud_reached) begin
                    frame_done = 1'b1;
                    stop_ok    = line;
                    if (line) begin
                        next_state = IDLE;
                    end
                end else begin
                    baud_sel = uart_rx_pkg::CTR_INC;
                end
            end

            default: begin
                next_state = IDLE;
            end
        endcase
    end

endmodule

// File: src/rx_input_filter.sv
module rx_input_filter #(
    parameter int NUM_CHANNELS = 4
) (
    input  logic                    clk,
    input  logic                    reset_b,
    input  logic [NUM_CHANNELS-1:0] rx_line,
    output logic [NUM_CHANNELS-1:0] clean_line
);

    logic [NUM_CHANNELS-1:0] sync_1;
    logic [NUM_CHANNELS-1:0] sync_2;
    logic [NUM_CHANNELS-1:0] sample_1;
    logic [NUM_CHANNELS-1:0] sample_2;
    logic [NUM_CHANNELS-1:0] majority;

    // Two of the last three synchronized samples must agree, which removes
    // any glitch of a single cycle.
    assign majority = (sync_2 & sample_1) |
                      (sync_2 & sample_2) |
                      (sample_1 & sample_2);

    // Everything resets high so the lines read as idle.
    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            sync_1     <= '1;
            sync_2     <= '1;
            sample_1   <= '1;
            sample_2   <= '1;
            clean_line <= '1;
        end else begin
            sync_1     <= rx_line;
            sync_2     <= sync_1;
            sample_1   <= sync_2;
            sample_2   <= sample_1;
            clean_line <= majority;
        end
    end

endmodule

// File: src/uart_rx_pkg.sv
package uart_rx_pkg;

    // Frames are 8N1, so every channel collects this many data bits.
    localparam int DATA_BITS = 8;

    // Commands for the baud and bit counters in the datapath.
    typedef enum logic [1:0] {
        CTR_ZERO = 2'b00,
        CTR_HOLD = 2'b10,
        CTR_INC  = 2'b11
    } ctr_sel_t;

    // Command for the receive shift register.
    typedef enum logic {
        SHIFT_HOLD = 1'b0,
        SHIFT_IN   = 1'b1
    } shift_sel_t;

endpackage
